// ==== Makefile ====
TOP = itag_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): itag.f $(shell cat itag.f)
	verilator --binary --timing --assert -f itag.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

lint:
	verilator --lint-only -Wall --timing -f itag.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== itag.f ====
source/itag_pkg.sv
source/itag_if.sv
source/itag_front.sv
source/itag_way.sv
source/itag_hit_merge.sv
source/itag_top.sv
verif/itag_assertions.sv
verif/itag_tb.sv

// ==== source/itag_front.sv ====
// Front end of the tag subsystem
// Lookup address registers, write priority resolution, per-set round robin

`timescale 1ns/1ps

module itag_front #(
	parameter int AMSB      = 31,
	parameter int SETS_LOG2 = 6,
	parameter int WAYS      = 2
) (
	input  logic             rclk,
	input  logic             arst_n,
	input  logic             fill,
	input  logic [AMSB:0]    fill_addr,
	input  logic             fill_err,
	input  logic             invalidate,
	input  logic             invalidate_line,
	input  logic [AMSB:0]    invalidate_addr,
	input  logic             rce,
	input  logic [AMSB:0]    pc,
	itag_cmd_if.front        cmd
);

	localparam int IDX_LO = itag_pkg::OFFSET_BITS;
	localparam int TAG_LO = itag_pkg::OFFSET_BITS + SETS_LOG2;
	localparam int SETS   = 2 ** SETS_LOG2;

	logic [AMSB:0]          rpc;
	logic [AMSB:0]          rpcp16;
	itag_pkg::itag_op_e     op;
	logic [SETS_LOG2-1:0]   fill_idx;
	logic [SETS_LOG2-1:0]   inval_idx;
	// One-hot victim pointer per set, way 0 first
	logic [WAYS-1:0]        victim [SETS];

	// ============================================================
	// Lookup address registers
	// ============================================================

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			rpc    <= '0;
			rpcp16 <= '0;
		end else if (rce) begin
			rpc    <= pc;
			// Second address wraps at the top of the address space
			rpcp16 <= pc + (AMSB+1)'(itag_pkg::HALF_STEP);
		end
	end

	assign cmd.look_idx0 = rpc[IDX_LO +: SETS_LOG2];
	assign cmd.look_tag0 = rpc[AMSB:TAG_LO];
	assign cmd.look_idx1 = rpcp16[IDX_LO +: SETS_LOG2];
	assign cmd.look_tag1 = rpcp16[AMSB:TAG_LO];

	// ============================================================
	// Write priority
	// ============================================================

	assign fill_idx  = fill_addr[IDX_LO +: SETS_LOG2];
	assign inval_idx = invalidate_addr[IDX_LO +: SETS_LOG2];

	// Invalidate all beats invalidate line beats fill
	always_comb begin
		if (invalidate)
			op = itag_pkg::OP_INVAL_ALL;
		else if (invalidate_line)
			op = itag_pkg::OP_INVAL_LINE;
		else if (fill)
			op = itag_pkg::OP_FILL;
		else
			op = itag_pkg::OP_NONE;
	end

	assign cmd.op      = op;
	assign cmd.wr_idx  = (op == itag_pkg::OP_INVAL_LINE) ? inval_idx : fill_idx;
	assign cmd.wr_tag  = fill_addr[AMSB:TAG_LO];
	assign cmd.wr_err  = fill_err;
	// Ways only look at this on a fill
	assign cmd.way_sel = victim[fill_idx];

	// ============================================================
	// Round-robin victim pointers
	// ============================================================

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < SETS; s++)
				victim[s] <= WAYS'(1);
		end else if (op == itag_pkg::OP_FILL) begin
			// Rotate left by one, modulo WAYS
			victim[fill_idx] <= (victim[fill_idx] << 1) | (victim[fill_idx] >> (WAYS-1));
		end
	end

endmodule

// ==== source/itag_hit_merge.sv ====
// Merge of per-way lookup results
// Hit flags, lowest hitting way number per lookup, combined error flag

`timescale 1ns/1ps

module itag_hit_merge #(
	parameter int WAYS = 2,
	localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	itag_res_if.merge        res [WAYS],
	output logic             hit0,
	output logic             hit1,
	output logic [WAY_W-1:0] hit_way0,
	output logic [WAY_W-1:0] hit_way1,
	output logic             err
);

	logic [WAYS-1:0] hit0_v;
	logic [WAYS-1:0] hit1_v;
	logic [WAYS-1:0] err0_v;
	logic [WAYS-1:0] err1_v;

	// Gather the interface array into flat vectors
	for (genvar i = 0; i < WAYS; i++) begin : g_gather
		assign hit0_v[i] = res[i].hit0;
		assign hit1_v[i] = res[i].hit1;
		assign err0_v[i] = res[i].err0;
		assign err1_v[i] = res[i].err1;
	end

	assign hit0 = |hit0_v;
	assign hit1 = |hit1_v;

	// Either lookup may flag the error
	assign err = (|err0_v) | (|err1_v);

	// ============================================================
	// Way encoders
	// ============================================================

	// Scan from the top so the lowest hitting way wins
	// Zero when nothing hits
	always_comb begin
		hit_way0 = '0;
		hit_way1 = '0;
		for (int i = WAYS-1; i >= 0; i--) begin
			if (hit0_v[i])
				hit_way0 = WAY_W'(i);
			if (hit1_v[i])
				hit_way1 = WAY_W'(i);
		end
	end

endmodule

// ==== source/itag_if.sv ====
// Interfaces inside the tag subsystem
// itag_cmd_if carries the write operation and both lookup keys to the ways
// itag_res_if carries one way's lookup results to the merge block

`timescale 1ns/1ps

interface itag_cmd_if #(
	parameter int AMSB      = 31,
	parameter int SETS_LOG2 = 6,
	parameter int WAYS      = 2
);

	// Tag holds every address bit above index and offset
	localparam int TAG_W = AMSB + 1 - itag_pkg::OFFSET_BITS - SETS_LOG2;

	// Write side, valid for the current cycle only
	itag_pkg::itag_op_e     op;
	// One-hot target way for a fill
	logic [WAYS-1:0]        way_sel;
	logic [SETS_LOG2-1:0]   wr_idx;
	logic [TAG_W-1:0]       wr_tag;
	logic                   wr_err;

	// Lookup keys from the registered fetch address and fetch address + 16
	logic [SETS_LOG2-1:0]   look_idx0;
	logic [TAG_W-1:0]       look_tag0;
	logic [SETS_LOG2-1:0]   look_idx1;
	logic [TAG_W-1:0]       look_tag1;

	modport front (
		output op, way_sel, wr_idx, wr_tag, wr_err,
		output look_idx0, look_tag0, look_idx1, look_tag1
	);

	modport way (
		input op, way_sel, wr_idx, wr_tag, wr_err,
		input look_idx0, look_tag0, look_idx1, look_tag1
	);

endinterface

interface itag_res_if;

	// Hit per lookup, and the stored error bit gated by that hit
	logic hit0;
	logic hit1;
	logic err0;
	logic err1;

	modport way (
		output hit0, hit1, err0, err1
	);

	modport merge (
		input hit0, hit1, err0, err1
	);

endinterface

// ==== source/itag_pkg.sv ====
// Shared definitions for the instruction-cache tag subsystem
// Line geometry constants and the write-operation encoding

package itag_pkg;

	// ============================================================
	// Line geometry
	// ============================================================

	// Byte offset inside a 32-byte line
	localparam int unsigned OFFSET_BITS = 5;

	// Second lookup address sits one half-line beyond the first
	// Covers a fetch that straddles the middle of a line
	localparam int unsigned HALF_STEP = 16;

	// ============================================================
	// Write operations
	// ============================================================

	// One operation per cycle, already prioritized by the front end
	// OP_INVAL_ALL  clears every valid and error bit in all ways
	// OP_INVAL_LINE clears the valid bit of one set in all ways
	// OP_FILL       loads a tag into the selected way of one set
	typedef enum logic [1:0] {
		OP_NONE       = 2'd0,
		OP_FILL       = 2'd1,
		OP_INVAL_LINE = 2'd2,
		OP_INVAL_ALL  = 2'd3
	} itag_op_e;

endpackage

// ==== source/itag_top.sv ====
// Top level of the instruction-cache tag subsystem
// Front end, generated tag ways and hit merge, joined by interfaces

`timescale 1ns/1ps

module itag_top #(
	parameter int AMSB      = 31,
	parameter int SETS_LOG2 = 6,
	parameter int WAYS      = 2,
	localparam int WAY_W    = (WAYS > 1) ? $clog2(WAYS) : 1
) (
	input  logic             rclk,
	input  logic             arst_n,
	// Fill and invalidate side
	input  logic             fill,
	input  logic [AMSB:0]    fill_addr,
	input  logic             fill_err,
	input  logic             invalidate,
	input  logic             invalidate_line,
	input  logic [AMSB:0]    invalidate_addr,
	// Lookup side
	input  logic             rce,
	input  logic [AMSB:0]    pc,
	output logic             hit0,
	output logic             hit1,
	output logic [WAY_W-1:0] hit_way0,
	output logic [WAY_W-1:0] hit_way1,
	output logic             err
);

	itag_cmd_if #(
		.AMSB      (AMSB),
		.SETS_LOG2 (SETS_LOG2),
		.WAYS      (WAYS)
	) cmd_if ();

	// One result bundle per way
	itag_res_if res_if [WAYS] ();

	itag_front #(
		.AMSB      (AMSB),
		.SETS_LOG2 (SETS_LOG2),
		.WAYS      (WAYS)
	) u_front (
		.rclk            (rclk),
		.arst_n          (arst_n),
		.fill            (fill),
		.fill_addr       (fill_addr),
		.fill_err        (fill_err),
		.invalidate      (invalidate),
		.invalidate_line (invalidate_line),
		.invalidate_addr (invalidate_addr),
		.rce             (rce),
		.pc              (pc),
		.cmd             (cmd_if.front)
	);

	// ============================================================
	// Tag ways
	// ============================================================

	for (genvar g = 0; g < WAYS; g++) begin : g_way
		itag_way #(
			.AMSB      (AMSB),
			.SETS_LOG2 (SETS_LOG2)
		) u_way (
			.rclk       (rclk),
			.arst_n     (arst_n),
			.cmd        (cmd_if.way),
			.way_id_hot (cmd_if.way_sel[g]),
			.res        (res_if[g].way)
		);
	end

	itag_hit_merge #(
		.WAYS (WAYS)
	) u_merge (
		.res      (res_if),
		.hit0     (hit0),
		.hit1     (hit1),
		.hit_way0 (hit_way0),
		.hit_way1 (hit_way1),
		.err      (err)
	);

endmodule

// ==== source/itag_way.sv ====
// One way of the instruction-cache tags
// Tag memory, valid and error bits, two lookup comparators

`timescale 1ns/1ps

module itag_way #(
	parameter int AMSB      = 31,
	parameter int SETS_LOG2 = 6
) (
	input  logic        rclk,
	input  logic        arst_n,
	itag_cmd_if.way     cmd,
	// This way's bit of the fill way select
	input  logic        way_id_hot,
	itag_res_if.way     res
);

	localparam int TAG_W = AMSB + 1 - itag_pkg::OFFSET_BITS - SETS_LOG2;
	localparam int SETS  = 2 ** SETS_LOG2;

	logic [TAG_W-1:0]   tag_mem [SETS];
	logic [SETS-1:0]    valid;
	logic [SETS-1:0]    err_bits;
	logic               fill_here;
	logic               match0;
	logic               match1;

	assign fill_here = (cmd.op == itag_pkg::OP_FILL) && way_id_hot;

	// ============================================================
	// Tag storage
	// ============================================================

	// Contents are meaningless until the valid bit is set
	always_ff @(posedge rclk) begin
		if (fill_here)
			tag_mem[cmd.wr_idx] <= cmd.wr_tag;
	end

	// ============================================================
	// Valid and error state
	// ============================================================

	always_ff @(posedge rclk or negedge arst_n) begin
		if (!arst_n) begin
			valid    <= '0;
			err_bits <= '0;
		end else begin
			case (cmd.op)
				itag_pkg::OP_INVAL_ALL: begin
					valid    <= '0;
					err_bits <= '0;
				end
				itag_pkg::OP_INVAL_LINE: begin
					// Error bit left in place, masked by the cleared valid
					valid[cmd.wr_idx] <= 1'b0;
				end
				itag_pkg::OP_FILL: begin
					if (way_id_hot) begin
						valid[cmd.wr_idx]    <= 1'b1;
						err_bits[cmd.wr_idx] <= cmd.wr_err;
					end
				end
				default: begin
				end
			endcase
		end
	end

	// ============================================================
	// Lookup compare
	// ============================================================

	// Combinational read, so a write shows up right after its edge
	assign match0 = (tag_mem[cmd.look_idx0] == cmd.look_tag0);
	assign match1 = (tag_mem[cmd.look_idx1] == cmd.look_tag1);

	// Hit needs a valid entry
	assign res.hit0 = valid[cmd.look_idx0] && match0;
	assign res.hit1 = valid[cmd.look_idx1] && match1;

	// Error only reported for the line that actually hit
	assign res.err0 = res.hit0 && err_bits[cmd.look_idx0];
	assign res.err1 = res.hit1 && err_bits[cmd.look_idx1];

endmodule

// ==== verif/itag_assertions.sv ====
// Concurrent checks on the tag subsystem outputs
// Bound into itag_top

`timescale 1ns/1ps

module itag_assertions #(
	parameter int WAY_W = 1
) (
	input logic             rclk,
	input logic             arst_n,
	input logic             invalidate,
	input logic             hit0,
	input logic             hit1,
	input logic [WAY_W-1:0] hit_way0,
	input logic [WAY_W-1:0] hit_way1,
	input logic             err
);

	// Failure count, read by the testbench at the end
	int unsigned error_count = 0;

	// Error flag only ever comes with a hit
	a_err_needs_hit: assert property (@(posedge rclk) disable iff (!arst_n)
		err |-> (hit0 || hit1))
	else begin
		error_count++;
		$error("err high without any hit");
	end

	// Nothing survives a full invalidate
	a_inval_all_clears: assert property (@(posedge rclk) disable iff (!arst_n)
		invalidate |=> (!hit0 && !hit1))
	else begin
		error_count++;
		$error("hit one cycle after invalidate");
	end

	// Way numbers stay at zero on a miss
	a_way0_idle: assert property (@(posedge rclk) disable iff (!arst_n)
		!hit0 |-> (hit_way0 == '0))
	else begin
		error_count++;
		$error("hit_way0 nonzero while hit0 low");
	end

	a_way1_idle: assert property (@(posedge rclk) disable iff (!arst_n)
		!hit1 |-> (hit_way1 == '0))
	else begin
		error_count++;
		$error("hit_way1 nonzero while hit1 low");
	end

	// Quiet outputs while reset is held
	a_reset_quiet: assert property (@(posedge rclk)
		!arst_n |-> (!hit0 && !hit1 && !err))
	else begin
		error_count++;
		$error("output active during reset");
	end

endmodule

bind itag_top itag_assertions #(
	.WAY_W (WAY_W)
) u_assertions (
	.rclk       (rclk),
	.arst_n     (arst_n),
	.invalidate (invalidate),
	.hit0       (hit0),
	.hit1       (hit1),
	.hit_way0   (hit_way0),
	.hit_way1   (hit_way1),
	.err        (err)
);

// ==== verif/itag_tb.sv ====
// Testbench for the instruction-cache tag subsystem
// Clock and reset, stimulus and expectation table, value check, watchdog

`timescale 1ns/1ps

module itag_tb;

	localparam int AMSB      = 31;
	localparam int SETS_LOG2 = 6;
	// Two ways by default, so one bit of way number
	localparam int WAY_W     = 1;
	localparam int TAG_W     = AMSB + 1 - itag_pkg::OFFSET_BITS - SETS_LOG2;

	// Fixed tags, far apart
	localparam logic [TAG_W-1:0] TAG_A = 21'h00123;
	localparam logic [TAG_W-1:0] TAG_B = 21'h0abcd;
	localparam logic [TAG_W-1:0] TAG_C = 21'h15555;

	// Sets used by the table
	localparam logic [SETS_LOG2-1:0] SET_A        = 6'd3;
	localparam logic [SETS_LOG2-1:0] SET_NEXT     = 6'd4;
	localparam logic [SETS_LOG2-1:0] SET_RR       = 6'd9;
	localparam logic [SETS_LOG2-1:0] SET_ERR_PREV = 6'd19;
	localparam logic [SETS_LOG2-1:0] SET_ERR      = 6'd20;
	localparam logic [SETS_LOG2-1:0] SET_RND      = 6'd40;

	typedef enum logic [2:0] {
		ACT_LOOKUP,
		ACT_FILL,
		ACT_INVAL_LINE,
		ACT_INVAL_ALL,
		// Line invalidate and fill in the same cycle
		ACT_INVAL_FILL,
		// No lookup and no write, so the registered address must hold
		ACT_HOLD
	} act_e;

	// One table row: action, address, fill error, expected outputs
	typedef struct packed {
		act_e             act;
		logic [AMSB:0]    addr;
		logic             ferr;
		logic             hit0;
		logic             hit1;
		logic [WAY_W-1:0] way0;
		logic [WAY_W-1:0] way1;
		logic             err;
	} entry_t;

	logic             rclk = 1'b0;
	logic             arst_n;
	logic             fill;
	logic [AMSB:0]    fill_addr;
	logic             fill_err;
	logic             invalidate;
	logic             invalidate_line;
	logic [AMSB:0]    invalidate_addr;
	logic             rce;
	logic [AMSB:0]    pc;
	logic             hit0;
	logic             hit1;
	logic [WAY_W-1:0] hit_way0;
	logic [WAY_W-1:0] hit_way1;
	logic             err;

	entry_t           table_q [$];
	logic [TAG_W-1:0] rnd_tag;
	logic             table_ready = 1'b0;

	itag_top UUT (
		.rclk            (rclk),
		.arst_n          (arst_n),
		.fill            (fill),
		.fill_addr       (fill_addr),
		.fill_err        (fill_err),
		.invalidate      (invalidate),
		.invalidate_line (invalidate_line),
		.invalidate_addr (invalidate_addr),
		.rce             (rce),
		.pc              (pc),
		.hit0            (hit0),
		.hit1            (hit1),
		.hit_way0        (hit_way0),
		.hit_way1        (hit_way1),
		.err             (err)
	);

	// 4 ns period
	always #2 rclk = ~rclk;

	// ============================================================
	// Helpers
	// ============================================================

	function automatic logic [AMSB:0] line_addr(input logic [TAG_W-1:0] tag,
			input logic [SETS_LOG2-1:0] idx, input logic [itag_pkg::OFFSET_BITS-1:0] off);
		return {tag, idx, off};
	endfunction

	task automatic add_entry(input act_e act, input logic [AMSB:0] addr, input logic ferr,
			input logic h0, input logic h1, input logic [WAY_W-1:0] w0,
			input logic [WAY_W-1:0] w1, input logic e);
		entry_t ent;
		ent = '{act: act, addr: addr, ferr: ferr, hit0: h0, hit1: h1,
			way0: w0, way1: w1, err: e};
		table_q.push_back(ent);
	endtask

	task automatic check_value(input int idx, input string name,
			input logic [31:0] actual, input logic [31:0] expected);
		if (actual !== expected) begin
			$display("[FAIL] entry %0d %s: got 0x%0h, expected 0x%0h",
				idx, name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "Output mismatch at table entry %0d", idx);
		end
	endtask

	// Rows other than a hold also look up their own address, so the write is seen at once
	// Address goes only to the write channel the row uses
	task automatic drive_entry(input entry_t ent);
		fill            = (ent.act == ACT_FILL) || (ent.act == ACT_INVAL_FILL);
		fill_addr       = fill ? ent.addr : '0;
		fill_err        = ent.ferr;
		invalidate      = (ent.act == ACT_INVAL_ALL);
		invalidate_line = (ent.act == ACT_INVAL_LINE) || (ent.act == ACT_INVAL_FILL);
		invalidate_addr = invalidate_line ? ent.addr : '0;
		rce             = (ent.act != ACT_HOLD);
		pc              = ent.addr;
	endtask

	task automatic idle_inputs();
		fill            = 1'b0;
		fill_addr       = '0;
		fill_err        = 1'b0;
		invalidate      = 1'b0;
		invalidate_line = 1'b0;
		invalidate_addr = '0;
		rce             = 1'b0;
		pc              = '0;
	endtask

	task automatic check_entry(input int idx, input entry_t ent);
		check_value(idx, "hit0", 32'(hit0), 32'(ent.hit0));
		check_value(idx, "hit1", 32'(hit1), 32'(ent.hit1));
		check_value(idx, "hit_way0", 32'(hit_way0), 32'(ent.way0));
		check_value(idx, "hit_way1", 32'(hit_way1), 32'(ent.way1));
		check_value(idx, "err", 32'(err), 32'(ent.err));
	endtask

	// ============================================================
	// Stimulus and expectation table
	// ============================================================

	// Columns: action, address, fill error, hit0, hit1, way0, way1, err
	task automatic build_table();
		// Nothing valid after reset
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_A, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_B, SET_RR, 5'd16), 1'b0, 0, 0, 0, 0, 0);
		// Fill then look up, second address inside or past the line
		add_entry(ACT_FILL, line_addr(TAG_A, SET_A, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_A, 5'd8), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_A, 5'd16), 1'b0, 1, 0, 0, 0, 0);
		add_entry(ACT_FILL, line_addr(TAG_A, SET_NEXT, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_A, 5'd16), 1'b0, 1, 1, 0, 0, 0);
		// Round robin in one set, third fill evicts way 0
		add_entry(ACT_FILL, line_addr(TAG_A, SET_RR, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_FILL, line_addr(TAG_B, SET_RR, 5'd0), 1'b0, 1, 1, 1, 1, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_RR, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_B, SET_RR, 5'd16), 1'b0, 1, 0, 1, 0, 0);
		add_entry(ACT_FILL, line_addr(TAG_C, SET_RR, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_RR, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_B, SET_RR, 5'd0), 1'b0, 1, 1, 1, 1, 0);
		// Held lookup keeps showing way 1 of the round-robin set
		add_entry(ACT_HOLD, line_addr(TAG_A, SET_A, 5'd0), 1'b0, 1, 1, 1, 1, 0);
		// Line invalidate, neighbour set untouched
		add_entry(ACT_INVAL_LINE, line_addr(TAG_A, SET_A, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_NEXT, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_A, 5'd16), 1'b0, 0, 1, 0, 0, 0);
		// Invalidate beats fill, and the victim pointer stays put
		add_entry(ACT_INVAL_FILL, line_addr(TAG_B, SET_NEXT, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_FILL, line_addr(TAG_C, SET_NEXT, 5'd0), 1'b0, 1, 1, 1, 1, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_NEXT, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		// Error bit follows the hitting lookup
		add_entry(ACT_FILL, line_addr(TAG_A, SET_ERR, 5'd0), 1'b1, 1, 1, 0, 0, 1);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_ERR, 5'd16), 1'b0, 1, 0, 0, 0, 1);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_ERR_PREV, 5'd16), 1'b0, 0, 1, 0, 0, 1);
		add_entry(ACT_LOOKUP, line_addr(TAG_B, SET_ERR, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		// Random tag in a set of its own
		add_entry(ACT_FILL, line_addr(rnd_tag, SET_RND, 5'd0), 1'b0, 1, 1, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(rnd_tag, SET_RND, 5'd8), 1'b0, 1, 1, 0, 0, 0);
		// Invalidate all clears hits and errors everywhere
		add_entry(ACT_INVAL_ALL, line_addr(TAG_B, SET_RR, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_C, SET_NEXT, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(TAG_A, SET_ERR, 5'd0), 1'b0, 0, 0, 0, 0, 0);
		add_entry(ACT_LOOKUP, line_addr(rnd_tag, SET_RND, 5'd0), 1'b0, 0, 0, 0, 0, 0);
	endtask

	// ============================================================
	// Main sequence and watchdog
	// ============================================================

	initial begin : main
		arst_n = 1'b0;
		idle_inputs();
		void'($urandom(32'h414239c5));
		rnd_tag = TAG_W'($urandom());
		build_table();
		table_ready = 1'b1;
		repeat (10) @(posedge rclk);
		@(negedge rclk);
		arst_n = 1'b1;
		// Apply a row, then check it one falling edge later
		for (int i = 0; i < table_q.size(); i++) begin
			drive_entry(table_q[i]);
			@(negedge rclk);
			check_entry(i, table_q[i]);
		end
		idle_inputs();
		@(negedge rclk);
		if (UUT.u_assertions.error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	// Four cycles per row plus the reset time
	initial begin : watchdog
		wait (table_ready);
		#(table_q.size() * 4 * 4 + 10 * 4);
		$display("Timeout: the table did not finish in time");
		$display("CHECKS FAILED");
		$fatal(1, "Watchdog expired");
	end

endmodule
